// ==== Makefile ====
# Verilator build and run of the zero-pad front end testbench
TOP := zero_pad_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sim.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== rtl/capture_buffer.sv ====
//**************************************************************************
// frame_len must be a power of two, each bank holds frame_len/2 pairs
// banks are released strictly in fill order, one release per framed bank
//**************************************************************************

`timescale 1ns/1ns

module capture_buffer import xcorr_pkg::*; #(
  parameter  int unsigned frame_len = 256,
  localparam int unsigned half_len  = frame_len / 2,
  localparam int unsigned addr_w    = $clog2(half_len)
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cond_valid,
  input  logic signed [data_w-1:0] x_cond,
  input  logic signed [data_w-1:0] y_cond,
  input  logic                     rd_bank,        // from the framer
  input  logic [addr_w-1:0]        rd_addr,
  input  logic                     bank_release,   // last beat of a frame taken
  output logic                     bank_full,
  output logic signed [data_w-1:0] x_rd_data,      // one cycle after rd_addr
  output logic signed [data_w-1:0] y_rd_data,
  output logic                     overrun
);

  // bank in the msb of the memory index
  logic signed [data_w-1:0] x_mem [2*half_len];
  logic signed [data_w-1:0] y_mem [2*half_len];

  logic              wr_bank;   // bank being filled
  logic [addr_w-1:0] wr_addr;
  logic [1:0]        full;      // one flag per bank
  logic              oldest;    // next bank to hand to the framer
  logic              both_full;
  logic              wr_en;
  logic              wr_last;

  assign both_full = &full;
  assign wr_en     = cond_valid && !both_full;        // drop while no bank is free
  assign wr_last   = (wr_addr == addr_w'(half_len - 1));
  assign bank_full = full[oldest];

  // fill and release bookkeeping
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_bank <= 1'b0;
      wr_addr <= '0;
      full    <= 2'b00;
      oldest  <= 1'b0;
      overrun <= 1'b0;
    end else begin
      overrun <= cond_valid && both_full;  // one pulse per dropped pair
      if (wr_en) begin
        wr_addr <= wr_addr + 1'b1;          // wraps at half_len
        if (wr_last) begin
          full[wr_bank] <= 1'b1;            // full on the edge of the last write
          wr_bank       <= ~wr_bank;
        end
      end
      // never the bank being written, so no clash with the set above
      if (bank_release) begin
        full[oldest] <= 1'b0;
        oldest       <= ~oldest;
      end
    end
  end

  // sample memories, both channels at one address
  always_ff @(posedge clk) begin
    if (wr_en) begin
      x_mem[{wr_bank, wr_addr}] <= x_cond;
      y_mem[{wr_bank, wr_addr}] <= y_cond;
    end
    x_rd_data <= x_mem[{rd_bank, rd_addr}];  // registered read
    y_rd_data <= y_mem[{rd_bank, rd_addr}];
  end

endmodule

// ==== rtl/pad_framer.sv ====
//**************************************************************************
// every beat reads the bank, the padded channel is masked to zero
// frame_len must be a power of two, at least 4
//**************************************************************************

`timescale 1ns/1ns

module pad_framer import xcorr_pkg::*; #(
  parameter  int unsigned frame_len = 256,
  localparam int unsigned half_len  = frame_len / 2,
  localparam int unsigned addr_w    = $clog2(half_len),
  localparam int unsigned user_w    = $clog2(frame_len)
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     bank_full,
  input  logic signed [data_w-1:0] x_rd_data,
  input  logic signed [data_w-1:0] y_rd_data,
  input  logic                     m_tready,
  output logic                     rd_bank,
  output logic [addr_w-1:0]        rd_addr,
  output logic                     bank_release,
  output logic [tdata_w-1:0]       x_tdata,
  output logic [tdata_w-1:0]       y_tdata,
  output logic                     m_tvalid,
  output logic                     m_tlast,
  output logic [user_w-1:0]        m_tuser
);

  localparam logic [user_w-1:0] last_beat = user_w'(frame_len - 1);

  framer_state_t state;
  logic               iss_done;   // all n reads of this frame issued
  logic               rd_pend;    // read data on the bus this cycle
  logic [user_w-1:0]  pend_user;  // beat index of that read
  logic               pf_valid;   // prefetch entry behind the output
  logic [tdata_w-1:0] pf_x;
  logic [tdata_w-1:0] pf_y;
  logic [user_w-1:0]  pf_user;
  logic [tdata_w-1:0] in_x;
  logic [tdata_w-1:0] in_y;
  logic [1:0]         occ;
  logic               xfer;
  logic               load_out;
  logic               issue;

  // trail half carries x, lead half carries y
  assign in_x = pend_user[user_w-1] ? {{data_w{1'b0}}, x_rd_data} : '0;
  assign in_y = pend_user[user_w-1] ? '0 : {{data_w{1'b0}}, y_rd_data};

  assign xfer         = m_tvalid && m_tready;
  assign load_out     = !m_tvalid || m_tready;   // output register free next edge
  assign bank_release = xfer && m_tlast;

  // beats held or in flight, a new read needs a slot two edges on
  assign occ   = 2'(m_tvalid) + 2'(pf_valid) + 2'(rd_pend);
  assign issue = (state != idle) && !iss_done && (occ <= 2'd1 + 2'(xfer));

  // read sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= idle;
      rd_bank  <= 1'b0;
      rd_addr  <= '0;
      iss_done <= 1'b0;
      rd_pend  <= 1'b0;
    end else begin
      rd_pend <= issue;
      case (state)
        idle: begin
          if (bank_full) begin
            state    <= lead_half;
            rd_addr  <= '0;
            iss_done <= 1'b0;
          end
        end
        lead_half: begin
          if (issue) begin
            rd_addr <= rd_addr + 1'b1;
            if (rd_addr == addr_w'(half_len - 1)) state <= trail_half;
          end
        end
        trail_half: begin
          if (issue) begin
            rd_addr <= rd_addr + 1'b1;
            if (rd_addr == addr_w'(half_len - 1)) iss_done <= 1'b1;
          end
          if (bank_release) begin  // buffer frees the same bank
            state   <= idle;
            rd_bank <= ~rd_bank;   // banks come in fill order
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // beat index follows its read
  always_ff @(posedge clk) begin
    if (issue) pend_user <= {state == trail_half, rd_addr};
  end

  // output and prefetch occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
      pf_valid <= 1'b0;
    end else if (load_out) begin
      m_tvalid <= pf_valid || rd_pend;  // prefetch is always the older beat
      m_tlast  <= pf_valid ? (pf_user == last_beat) : (rd_pend && pend_user == last_beat);
      pf_valid <= pf_valid && rd_pend;
    end else begin
      pf_valid <= pf_valid || rd_pend;  // stalled, park the arriving beat
    end
  end

  // beat payload
  always_ff @(posedge clk) begin
    if (load_out) begin
      if (pf_valid) begin
        x_tdata <= pf_x;
        y_tdata <= pf_y;
        m_tuser <= pf_user;
      end else begin
        x_tdata <= in_x;
        y_tdata <= in_y;
        m_tuser <= pend_user;
      end
    end
    if (rd_pend && (!load_out || pf_valid)) begin
      pf_x    <= in_x;
      pf_y    <= in_y;
      pf_user <= pend_user;
    end
  end

endmodule

// ==== rtl/sample_conditioner.sv ====
//**************************************************************************
// gain_shift must stay in 0..6 or the most negative code overflows data_w
// x and y share one strobe, result is valid one cycle later
//**************************************************************************

`timescale 1ns/1ns

module sample_conditioner import xcorr_pkg::*; #(
  parameter int unsigned gain_shift = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     sample_valid,   // one-cycle strobe
  input  logic [sample_w-1:0]      x_sample,       // offset binary
  input  logic [sample_w-1:0]      y_sample,
  output logic                     cond_valid,
  output logic signed [data_w-1:0] x_cond,
  output logic signed [data_w-1:0] y_cond
);

  // offset removal, sign extension and gain for one raw code
  function automatic logic signed [data_w-1:0] condition(input logic [sample_w-1:0] raw);
    logic signed [data_w-1:0] centered;
    centered = data_w'(raw) - data_w'(adc_mid);  // 0 -> -512, 1023 -> +511
    return centered <<< gain_shift;              // headroom left for the fft growth
  endfunction

  // strobe register
  always_ff @(posedge clk) begin
    if (reset) begin
      cond_valid <= 1'b0;
    end else begin
      cond_valid <= sample_valid;
    end
  end

  // data registers, loaded only with the strobe
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      x_cond <= condition(x_sample);
      y_cond <= condition(y_sample);
    end
  end

endmodule

// ==== rtl/xcorr_pkg.sv ====
//**************************************************************************
// shared widths and encodings for the two-channel zero-pad front end
// raw samples are offset binary, output parts are signed two's complement
//**************************************************************************

package xcorr_pkg;

  // raw adc word, one per channel per strobe
  localparam int unsigned sample_w = 10;

  // signed real or imaginary part toward the fft pair
  localparam int unsigned data_w = 16;

  // complex stream word, imaginary in the upper half
  localparam int unsigned tdata_w = 2 * data_w;

  // mid-scale code, maps to zero after offset removal
  localparam logic [sample_w-1:0] adc_mid = sample_w'(1 << (sample_w - 1));

  // framer states
  // lead_half  beats 0 .. n/2-1, y data and x zero
  // trail_half beats n/2 .. n-1, x data and y zero
  typedef enum logic [1:0] {
    idle       = 2'd0,  // waiting for a full bank
    lead_half  = 2'd1,
    trail_half = 2'd2
  } framer_state_t;

endpackage

// ==== rtl/zero_pad_top.sv ====
//**************************************************************************
// frame_len is the fft length n, a power of two, at least 4
// one m_tvalid and m_tready for both channels, the fft pair runs in lockstep
//**************************************************************************

`timescale 1ns/1ns

module zero_pad_top import xcorr_pkg::*; #(
  parameter  int unsigned frame_len  = 256,
  parameter  int unsigned gain_shift = 4,
  localparam int unsigned user_w     = $clog2(frame_len)
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                sample_valid,
  input  logic [sample_w-1:0] x_sample,
  input  logic [sample_w-1:0] y_sample,
  input  logic                m_tready,
  output logic [tdata_w-1:0]  x_tdata,    // {imag, real}
  output logic [tdata_w-1:0]  y_tdata,
  output logic                m_tvalid,
  output logic                m_tlast,
  output logic [user_w-1:0]   m_tuser,    // beat index
  output logic                overrun
);

  localparam int unsigned addr_w = $clog2(frame_len / 2);

  logic                     cond_valid;
  logic signed [data_w-1:0] x_cond;
  logic signed [data_w-1:0] y_cond;
  logic                     bank_full;
  logic                     bank_release;
  logic                     rd_bank;
  logic [addr_w-1:0]        rd_addr;
  logic signed [data_w-1:0] x_rd_data;
  logic signed [data_w-1:0] y_rd_data;

  sample_conditioner #(.gain_shift(gain_shift)) u_sample_conditioner (
    .clk(clk),
    .reset(reset),
    .sample_valid(sample_valid),
    .x_sample(x_sample),
    .y_sample(y_sample),
    .cond_valid(cond_valid),
    .x_cond(x_cond),
    .y_cond(y_cond)
  );

  // ping-pong capture, drops pairs only with both banks full
  capture_buffer #(.frame_len(frame_len)) u_capture_buffer (
    .clk(clk),
    .reset(reset),
    .cond_valid(cond_valid),
    .x_cond(x_cond),
    .y_cond(y_cond),
    .rd_bank(rd_bank),
    .rd_addr(rd_addr),
    .bank_release(bank_release),
    .bank_full(bank_full),
    .x_rd_data(x_rd_data),
    .y_rd_data(y_rd_data),
    .overrun(overrun)
  );

  pad_framer #(.frame_len(frame_len)) u_pad_framer (
    .clk(clk),
    .reset(reset),
    .bank_full(bank_full),
    .x_rd_data(x_rd_data),
    .y_rd_data(y_rd_data),
    .m_tready(m_tready),
    .rd_bank(rd_bank),
    .rd_addr(rd_addr),
    .bank_release(bank_release),
    .x_tdata(x_tdata),
    .y_tdata(y_tdata),
    .m_tvalid(m_tvalid),
    .m_tlast(m_tlast),
    .m_tuser(m_tuser)
  );

endmodule

// ==== sim.f ====
rtl/xcorr_pkg.sv
rtl/sample_conditioner.sv
rtl/capture_buffer.sv
rtl/pad_framer.sv
rtl/zero_pad_top.sv
sim/zero_pad_asserts.sv
sim/zero_pad_tb.sv

// ==== sim/zero_pad_asserts.sv ====
//**************************************************************************
// stream checks bound into zero_pad_top, frame_len taken from the instance
//**************************************************************************

`timescale 1ns/1ns

module zero_pad_asserts import xcorr_pkg::*; #(
  parameter  int unsigned frame_len = 256,
  localparam int unsigned user_w    = $clog2(frame_len)
) (
  input logic               clk,
  input logic               reset,
  input logic               m_tvalid,
  input logic               m_tready,
  input logic               m_tlast,
  input logic [user_w-1:0]  m_tuser,
  input logic [tdata_w-1:0] x_tdata,
  input logic [tdata_w-1:0] y_tdata
);

  localparam logic [user_w-1:0] last_beat = user_w'(frame_len - 1);

  int error_count = 0;

  // offered beat stays until taken
  valid_held: assert property (@(posedge clk) disable iff (reset)
    m_tvalid && !m_tready |=> m_tvalid)
  else begin
    error_count++;
    $error("m_tvalid dropped before the transfer");
  end

  beat_stable: assert property (@(posedge clk) disable iff (reset)
    m_tvalid && !m_tready |=> $stable(x_tdata) && $stable(y_tdata)
                              && $stable(m_tuser) && $stable(m_tlast))
  else begin
    error_count++;
    $error("beat changed while stalled");
  end

  imag_zero: assert property (@(posedge clk) disable iff (reset)
    m_tvalid |-> x_tdata[tdata_w-1:data_w] == '0 && y_tdata[tdata_w-1:data_w] == '0)
  else begin
    error_count++;
    $error("imaginary half not zero");
  end

  // last beat of a frame is index n-1
  last_at_end: assert property (@(posedge clk) disable iff (reset)
    m_tvalid |-> m_tlast == (m_tuser == last_beat))
  else begin
    error_count++;
    $error("m_tlast does not match m_tuser");
  end

  quiet_after_reset: assert property (@(posedge clk) reset |=> !m_tvalid)
  else begin
    error_count++;
    $error("m_tvalid high in the cycle after reset");
  end

endmodule

bind zero_pad_top zero_pad_asserts #(.frame_len(frame_len)) u_zero_pad_asserts (
  .clk(clk),
  .reset(reset),
  .m_tvalid(m_tvalid),
  .m_tready(m_tready),
  .m_tlast(m_tlast),
  .m_tuser(m_tuser),
  .x_tdata(x_tdata),
  .y_tdata(y_tdata)
);

// ==== sim/zero_pad_tb.sv ====
//**************************************************************************
// runs zero_pad_top with n = 16 and gain shift 4, expects frames in capture order
// the model counts full banks from the m_tlast transfers it sees
//**************************************************************************

`timescale 1ns/1ns

module zero_pad_tb import xcorr_pkg::*; ();

  localparam int unsigned frame_len    = 16;
  localparam int unsigned gain_shift   = 4;
  localparam int unsigned half_len     = frame_len / 2;
  localparam int unsigned user_w       = $clog2(frame_len);
  localparam int unsigned n_samples    = 112;  // 32 + 8 + 48 + 24 strobes
  localparam int unsigned max_gap      = 14;   // longest strobe spacing in cycles
  localparam int unsigned n_frames     = 13;   // 4 + 1 + 6 + 2
  localparam int unsigned limit_cycles = (n_samples * max_gap + n_frames * frame_len * 4) * 2;

  // corner codes, mid-scale and both rails
  localparam logic [sample_w-1:0] codes [8] = '{
    10'd0, 10'd511, 10'd512, 10'd513, 10'd1023, 10'd1, 10'd1022, 10'd256
  };

  logic                clk;
  logic                reset;
  logic                sample_valid;
  logic [sample_w-1:0] x_sample;
  logic [sample_w-1:0] y_sample;
  logic                m_tready;
  logic [tdata_w-1:0]  x_tdata;
  logic [tdata_w-1:0]  y_tdata;
  logic                m_tvalid;
  logic                m_tlast;
  logic [user_w-1:0]   m_tuser;
  logic                overrun;

  logic [sample_w-1:0] cap_x [$];  // accepted pairs, capture order
  logic [sample_w-1:0] cap_y [$];
  bit                  cv_d;       // model of the conditioner stage
  logic [sample_w-1:0] x_d;
  logic [sample_w-1:0] y_d;
  bit                  exp_ovr;
  int                  mfill       = 0;  // pairs in the bank being filled
  int                  mfull       = 0;  // full banks, 0..2
  int                  drops       = 0;
  int                  ovr_seen    = 0;
  int                  frames_seen = 0;
  int                  beat        = 0;
  int unsigned         ready_mode  = 1;  // 0 low, 1 high, 2 random

  zero_pad_top #(.frame_len(frame_len), .gain_shift(gain_shift)) u_zero_pad_top (
    .clk(clk),
    .reset(reset),
    .sample_valid(sample_valid),
    .x_sample(x_sample),
    .y_sample(y_sample),
    .m_tready(m_tready),
    .x_tdata(x_tdata),
    .y_tdata(y_tdata),
    .m_tvalid(m_tvalid),
    .m_tlast(m_tlast),
    .m_tuser(m_tuser),
    .overrun(overrun)
  );

  // offset removal then gain, done in integer arithmetic
  function automatic logic [data_w-1:0] cond_ref(input logic [sample_w-1:0] raw);
    int v;
    v = (int'(raw) - 512) * (1 << gain_shift);
    return v[data_w-1:0];
  endfunction

  // expected {imag, real} of frame f at beat i
  function automatic logic [tdata_w-1:0] beat_ref(input int f, input int i, input bit y_chan);
    int k;
    k = f * half_len + (i % half_len);
    if (y_chan) begin
      if (i < half_len) return {{data_w{1'b0}}, cond_ref(cap_y[k])};  // y leads
      return '0;
    end
    if (i >= half_len) return {{data_w{1'b0}}, cond_ref(cap_x[k])};   // x trails
    return '0;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
    stop_run($sformatf("[ERROR] %s: got %h expected %h", sig, got, exp));
  endtask

  // one strobe, then gap idle cycles
  task automatic send_pair(input logic [sample_w-1:0] xs, input logic [sample_w-1:0] ys,
                           input int gap);
    @(posedge clk);
    sample_valid <= 1'b1;
    x_sample     <= xs;
    y_sample     <= ys;
    repeat (gap) begin
      @(posedge clk);
      sample_valid <= 1'b0;
    end
  endtask

  task automatic wait_frames(input int n);
    while (frames_seen < n) @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // downstream ready
  initial begin
    m_tready = 1'b0;
    forever begin
      @(posedge clk);
      case (ready_mode)
        0:       m_tready <= 1'b0;
        1:       m_tready <= 1'b1;
        default: m_tready <= 1'($urandom_range(1, 0));  // about half the cycles
      endcase
    end
  end

  // capture model, pre-edge values of all signals
  always @(posedge clk) begin : capture_model
    bit drop;
    if (!reset) begin
      assert (overrun == exp_ovr) else value_error("overrun", 32'(overrun), 32'(exp_ovr));
      drop    = cv_d && (mfull == 2);  // both banks held
      exp_ovr = drop;
      if (drop) drops++;
      if (cv_d && !drop) begin
        cap_x.push_back(x_d);
        cap_y.push_back(y_d);
        mfill++;
        if (mfill == half_len) begin
          mfill = 0;
          mfull++;
        end
      end
      if (m_tvalid && m_tready && m_tlast) mfull--;  // bank freed
      if (overrun) ovr_seen++;
    end else begin
      exp_ovr = 1'b0;
    end
    cv_d = sample_valid;
    x_d  = x_sample;
    y_d  = y_sample;
  end

  // compare every transfer
  always @(posedge clk) begin : compare
    logic [tdata_w-1:0] exp_x;
    logic [tdata_w-1:0] exp_y;
    if (!reset && m_tvalid && m_tready) begin
      assert ((frames_seen + 1) * half_len <= cap_x.size())
        else stop_run("a frame left before its samples were captured");
      exp_x = beat_ref(frames_seen, beat, 1'b0);
      exp_y = beat_ref(frames_seen, beat, 1'b1);
      assert (x_tdata == exp_x) else value_error("x_tdata", x_tdata, exp_x);
      assert (y_tdata == exp_y) else value_error("y_tdata", y_tdata, exp_y);
      assert (m_tuser == user_w'(beat)) else value_error("m_tuser", 32'(m_tuser), beat);
      assert (m_tlast == (beat == frame_len - 1))
        else value_error("m_tlast", 32'(m_tlast), 32'(beat == frame_len - 1));
      if (beat == frame_len - 1) begin
        beat = 0;
        frames_seen++;
      end else begin
        beat++;
      end
    end
    assert (u_zero_pad_top.u_zero_pad_asserts.error_count == 0)
      else stop_run("a stream protocol assertion failed");
  end

  initial begin : watchdog
    repeat (limit_cycles) @(posedge clk);
    stop_run("timeout, the expected frames did not all arrive");
  end

  initial begin : stimulus
    int k;
    void'($urandom(32'h6882_10a6));
    reset        = 1'b1;
    sample_valid = 1'b0;
    x_sample     = '0;
    y_sample     = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // padding and framing, ready always high
    for (k = 0; k < 4 * half_len; k++) send_pair(sample_w'($urandom), sample_w'($urandom), 2);
    wait_frames(4);

    // corner codes, y in reverse order
    for (k = 0; k < half_len; k++) send_pair(codes[k], codes[half_len - 1 - k], 2);
    wait_frames(5);

    // back-pressure at a slow sample rate
    ready_mode = 2;
    for (k = 0; k < 6 * half_len; k++) begin
      send_pair(sample_w'($urandom), sample_w'($urandom), 6 + $urandom_range(6, 0));
    end
    wait_frames(11);
    assert (drops == 0) else stop_run("samples were dropped at the slow rate");

    // overrun, both banks fill then n/2 pairs dropped
    ready_mode = 0;
    repeat (4) @(posedge clk);
    for (k = 0; k < 3 * half_len; k++) send_pair(sample_w'($urandom), sample_w'($urandom), 0);
    @(posedge clk);
    sample_valid <= 1'b0;
    repeat (8) @(posedge clk);  // last drop reaches overrun
    assert (ovr_seen == half_len) else value_error("overrun pulses", ovr_seen, half_len);
    ready_mode = 1;
    wait_frames(13);
    repeat (4 * frame_len) @(posedge clk);  // nothing more may leave

    if (frames_seen == n_frames && mfull == 0 && drops == half_len && !m_tvalid) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_run("frame count, bank count or drop count differs from the model at the end");
    end
  end

endmodule
